/* list.f */
hw/cache_pkg.sv
hw/apb_cache_port.sv
hw/cache_bank.sv
hw/mem_arbiter.sv
hw/backing_mem.sv
hw/cache_top.sv
tb/cache_assert.sv
tb/cache_tb.sv

/* Bender.yml */
package:
  name: banked_cache

sources:
  - files:
      - hw/cache_pkg.sv
      - hw/apb_cache_port.sv
      - hw/cache_bank.sv
      - hw/mem_arbiter.sv
      - hw/backing_mem.sv
      - hw/cache_top.sv
  - target: test
    files:
      - tb/cache_assert.sv
      - tb/cache_tb.sv

/* tb/cache_tb.sv */
module cache_tb;

    typedef struct packed {
        logic             is_read;
        logic [16:0]      addr;
        cache_pkg::word_t exp_data;
        cache_pkg::word_t got_data;
        logic             exp_err;
        logic             got_err;
    } check_t;

    logic                         clk;
    logic                         rst;
    logic                         psel;
    logic                         penable;
    logic                         pwrite;
    logic [cache_pkg::ADDR_W-1:0] paddr;
    cache_pkg::word_t             pwdata;
    cache_pkg::strb_t             pstrb;
    cache_pkg::word_t             prdata;
    logic                         pready;
    logic                         pslverr;

    logic [7:0]         mem_model [65536];
    logic [127:0]       tag_valid;      // One per {index, bank} set
    logic [5:0]         tag_tbl [128];
    cache_pkg::count_t  ref_hits;
    cache_pkg::count_t  ref_misses;
    check_t             result_q [$];
    int                 issued;
    int                 checked;
    int                 cycles;
    integer             seed;
    cache_pkg::word_t   rnd;
    cache_pkg::word_t   rnd_data;

    cache_top cache_top_inst (.*);

    bind cache_top cache_assert assert_inst (
        .clk          (clk),
        .rst          (rst),
        .pready       (pready),
        .prdata       (prdata),
        .bank_req     (bank_req),
        .bank_rsp     (bank_rsp),
        .bank_mem_rsp (bank_mem_rsp),
        .mem_req      (mem_req),
        .mem_rsp      (mem_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ******************************
    // Reference model
    // ******************************
    function automatic void count_access(input logic [16:0] addr);
        logic [6:0] set;
        set = addr[cache_pkg::BANK_BIT +: 7];
        if (tag_valid[set] && (tag_tbl[set] == addr[cache_pkg::TAG_LSB +: cache_pkg::TAG_W])) begin
            ref_hits++;
        end else begin
            ref_misses++;
        end
        tag_valid[set] = 1'b1;
        tag_tbl[set]   = addr[cache_pkg::TAG_LSB +: cache_pkg::TAG_W];
    endfunction

    function automatic cache_pkg::word_t ref_read(input logic [16:0] addr, output logic err);
        int base;
        err  = 1'b0;
        base = {addr[15:2], 2'b00};
        if (addr[16]) begin
            case (int'(addr[15:0]))
                cache_pkg::CTRL_FLUSH_OFS:  return '0;
                cache_pkg::CTRL_HITS_OFS:   return ref_hits;
                cache_pkg::CTRL_MISSES_OFS: return ref_misses;
                default: begin
                    err = 1'b1;
                    return '0;
                end
            endcase
        end
        count_access(addr);
        return {mem_model[base + 3], mem_model[base + 2], mem_model[base + 1], mem_model[base]};
    endfunction

    function automatic void ref_write(input logic [16:0] addr, input cache_pkg::word_t data,
                                      input cache_pkg::strb_t strb, output logic err);
        int base;
        err  = 1'b0;
        base = {addr[15:2], 2'b00};
        if (addr[16]) begin
            if (int'(addr[15:0]) == cache_pkg::CTRL_FLUSH_OFS) begin
                tag_valid = '0;  // Clean and invalidate
            end else begin
                err = 1'b1;
            end
        end else begin
            count_access(addr);
            for (int i = 0; i < 4; i++) begin
                if (strb[i]) begin
                    mem_model[base + i] = data[i * 8 +: 8];
                end
            end
        end
    endfunction

    function automatic logic [16:0] ctrl_addr(input int ofs);
        return {1'b1, ofs[15:0]};
    endfunction

    // ******************************
    // APB driver
    // ******************************
    task automatic apb_xfer(input logic write, input logic [16:0] addr,
                            input cache_pkg::word_t data, input cache_pkg::strb_t strb);
        check_t r;
        r.is_read = !write;
        r.addr    = addr;
        if (write) begin
            ref_write(addr, data, strb, r.exp_err);
            r.exp_data = '0;
        end else begin
            r.exp_data = ref_read(addr, r.exp_err);
        end
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = data;
        pstrb   = write ? strb : '0;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        while (!pready) begin
            @(negedge clk);
        end
        r.got_data = prdata;
        r.got_err  = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        result_q.push_back(r);
        issued++;
    endtask

    task automatic check_counters();
        apb_xfer(1'b0, ctrl_addr(cache_pkg::CTRL_HITS_OFS), '0, '0);
        apb_xfer(1'b0, ctrl_addr(cache_pkg::CTRL_MISSES_OFS), '0, '0);
    endtask

    // Compare process
    initial begin
        check_t r;
        forever begin
            @(negedge clk);
            while (result_q.size() > 0) begin
                r = result_q.pop_front();
                assert (r.got_err == r.exp_err) else begin
                    $display("FAILED at %0t: pslverr for address %h expected %b got %b",
                             $time, r.addr, r.exp_err, r.got_err);
                    $display("tests failed");
                    $fatal(1);
                end
                if (r.is_read && !r.exp_err) begin
                    assert (r.got_data == r.exp_data) else begin
                        $display("FAILED at %0t: prdata for address %h expected %h got %h",
                                 $time, r.addr, r.exp_data, r.got_data);
                        $display("tests failed");
                        $fatal(1);
                    end
                end
                checked++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= 40000) begin
            $display("timeout: the run did not finish within 40000 clock cycles");
            $display("tests failed");
            $fatal(1);
        end
    end

    // ******************************
    // Test sequence
    // ******************************
    initial begin
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        pstrb   = '0;
        seed    = 10;
        issued  = 0;
        checked = 0;
        cycles  = 0;
        ref_hits   = '0;
        ref_misses = '0;
        tag_valid  = '0;
        for (int i = 0; i < 65536; i++) begin
            mem_model[i] = 8'h00;
        end
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        // Zero after reset, then write and read back
        apb_xfer(1'b0, 17'h00000, '0, '0);
        apb_xfer(1'b1, 17'h00000, 32'hdead_beef, 4'hf);
        apb_xfer(1'b0, 17'h00000, '0, '0);
        apb_xfer(1'b0, 17'h0004c, '0, '0);
        check_counters();

        // Partial strobes
        apb_xfer(1'b1, 17'h00104, 32'h1122_3344, 4'hf);
        apb_xfer(1'b1, 17'h00104, 32'haabb_ccdd, 4'b0101);
        apb_xfer(1'b1, 17'h00100, 32'h5566_7788, 4'b1000);
        apb_xfer(1'b0, 17'h00104, '0, '0);
        apb_xfer(1'b0, 17'h00100, '0, '0);

        // Same bank and index, different tags
        apb_xfer(1'b1, 17'h00020, 32'h0a0a_0a0a, 4'hf);
        apb_xfer(1'b1, 17'h00420, 32'h0b0b_0b0b, 4'hf);
        apb_xfer(1'b0, 17'h00020, '0, '0);
        apb_xfer(1'b0, 17'h00420, '0, '0);
        check_counters();

        // Lines in both banks, flush, read back
        for (int i = 0; i < 8; i++) begin
            apb_xfer(1'b1, 17'h02000 + 17'(i * 8) + 17'((i % 2) * 4), 32'hc0de_0000 + i, 4'hf);
        end
        apb_xfer(1'b1, ctrl_addr(cache_pkg::CTRL_FLUSH_OFS), '0, 4'hf);
        for (int i = 0; i < 8; i++) begin
            apb_xfer(1'b0, 17'h02000 + 17'(i * 8) + 17'((i % 2) * 4), '0, '0);
        end
        check_counters();

        // Control window errors
        apb_xfer(1'b1, ctrl_addr(cache_pkg::CTRL_HITS_OFS), 32'h1234_5678, 4'hf);
        apb_xfer(1'b1, ctrl_addr(cache_pkg::CTRL_MISSES_OFS), 32'h1234_5678, 4'hf);
        apb_xfer(1'b1, ctrl_addr(12), 32'h1234_5678, 4'hf);
        apb_xfer(1'b0, ctrl_addr(16), '0, '0);
        apb_xfer(1'b0, ctrl_addr(cache_pkg::CTRL_FLUSH_OFS), '0, '0);
        check_counters();

        // Random mix, four tags over sixteen sets
        repeat (500) begin
            rnd      = $random(seed);
            rnd_data = $random(seed);
            apb_xfer(rnd[11], {1'b0, 4'b0000, rnd[1:0], 3'b000, rnd[6:2], 2'b00},
                     rnd_data, rnd[10:7]);
        end
        check_counters();

        repeat (2) @(negedge clk);
        if (checked == issued) begin
            $display("all tests passed");
        end else begin
            $display("not every transfer result was compared");
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* tb/cache_assert.sv */
module cache_assert (
    input logic                 clk,
    input logic                 rst,
    input logic                 pready,
    input cache_pkg::word_t     prdata,
    input cache_pkg::bank_req_t bank_req     [cache_pkg::NUM_BANKS],
    input cache_pkg::bank_rsp_t bank_rsp     [cache_pkg::NUM_BANKS],
    input cache_pkg::mem_rsp_t  bank_mem_rsp [cache_pkg::NUM_BANKS],
    input cache_pkg::mem_req_t  mem_req,
    input cache_pkg::mem_rsp_t  mem_rsp
);

    logic [cache_pkg::NUM_BANKS-1:0] grant_done;

    always_comb begin
        for (int b = 0; b < cache_pkg::NUM_BANKS; b++) begin
            grant_done[b] = bank_mem_rsp[b].done;
        end
    end

    prdata_known: assert property (@(posedge clk) disable iff (rst)
        pready |-> !$isunknown(prdata))
        else $error("prdata unknown while pready was high");

    mem_req_stable: assert property (@(posedge clk) disable iff (rst)
        mem_req.valid && !mem_rsp.done |=> $stable(mem_req))
        else $error("memory request changed while waiting for done");

    // Each memory completion goes to exactly one bank
    one_grant: assert property (@(posedge clk) disable iff (rst)
        mem_rsp.done |-> $onehot(grant_done))
        else $error("memory done not routed to exactly one bank");

    mem_done_valid: assert property (@(posedge clk) disable iff (rst)
        mem_rsp.done |-> mem_req.valid)
        else $error("memory done without a request");

    for (genvar b = 0; b < cache_pkg::NUM_BANKS; b++) begin : g_bank
        bank_done_valid: assert property (@(posedge clk) disable iff (rst)
            bank_rsp[b].done |-> bank_req[b].valid)
            else $error("bank done without a request");
    end

endmodule

/* hw/cache_top.sv */
module cache_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  logic [cache_pkg::ADDR_W-1:0] paddr,
    input  cache_pkg::word_t             pwdata,
    input  cache_pkg::strb_t             pstrb,
    output cache_pkg::word_t             prdata,
    output logic                         pready,
    output logic                         pslverr
);

    cache_pkg::bank_req_t            bank_req     [cache_pkg::NUM_BANKS];
    cache_pkg::bank_rsp_t            bank_rsp     [cache_pkg::NUM_BANKS];
    cache_pkg::mem_req_t             bank_mem_req [cache_pkg::NUM_BANKS];
    cache_pkg::mem_rsp_t             bank_mem_rsp [cache_pkg::NUM_BANKS];
    cache_pkg::mem_req_t             mem_req;
    cache_pkg::mem_rsp_t             mem_rsp;
    logic                            flush_start;
    logic [cache_pkg::NUM_BANKS-1:0] flush_done;

    apb_cache_port port_inst (
        .clk         (clk),
        .rst         (rst),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .pstrb       (pstrb),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .bank_req    (bank_req),
        .bank_rsp    (bank_rsp),
        .flush_start (flush_start),
        .flush_done  (flush_done)
    );

    // Banks interleaved on the low index bit
    for (genvar b = 0; b < cache_pkg::NUM_BANKS; b++) begin : g_bank
        cache_bank #(
            .BANK_ID (b)
        ) bank_inst (
            .clk         (clk),
            .rst         (rst),
            .req         (bank_req[b]),
            .rsp         (bank_rsp[b]),
            .flush_start (flush_start),
            .flush_done  (flush_done[b]),
            .mem_req     (bank_mem_req[b]),
            .mem_rsp     (bank_mem_rsp[b])
        );
    end

    mem_arbiter arb_inst (
        .clk          (clk),
        .rst          (rst),
        .bank_mem_req (bank_mem_req),
        .bank_mem_rsp (bank_mem_rsp),
        .mem_req      (mem_req),
        .mem_rsp      (mem_rsp)
    );

    backing_mem mem_inst (
        .clk (clk),
        .rst (rst),
        .req (mem_req),
        .rsp (mem_rsp)
    );

endmodule

/* hw/backing_mem.sv */
module backing_mem (
    input  logic                clk,
    input  logic                rst,
    input  cache_pkg::mem_req_t req,
    output cache_pkg::mem_rsp_t rsp
);

    cache_pkg::line_t mem [2**$bits(cache_pkg::line_addr_t)] = '{default: '0};

    logic                                        active_q;
    logic [$clog2(cache_pkg::MEM_LATENCY+1)-1:0] cnt_q;
    logic                                        done_q;
    cache_pkg::line_t                            rdata_q;
    logic                                        last;

    assign last      = active_q && (cnt_q == cache_pkg::MEM_LATENCY - 1);
    assign rsp.done  = done_q;
    assign rsp.rdata = rdata_q;

    // Latency counter
    always_ff @(posedge clk) begin
        if (rst) begin
            active_q <= 1'b0;
            cnt_q    <= '0;
            done_q   <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (!active_q) begin
                if (req.valid && !done_q) begin  // Request still up in done cycle
                    active_q <= 1'b1;
                    cnt_q    <= 1'b1;
                end
            end else if (last) begin
                active_q <= 1'b0;
                done_q   <= 1'b1;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (last) begin
            if (req.write) begin
                mem[req.line_addr] <= req.wdata;  // Whole line
            end else begin
                rdata_q <= mem[req.line_addr];
            end
        end
    end

endmodule

/* hw/mem_arbiter.sv */
module mem_arbiter (
    input  logic                clk,
    input  logic                rst,
    input  cache_pkg::mem_req_t bank_mem_req [cache_pkg::NUM_BANKS],
    output cache_pkg::mem_rsp_t bank_mem_rsp [cache_pkg::NUM_BANKS],
    output cache_pkg::mem_req_t mem_req,
    input  cache_pkg::mem_rsp_t mem_rsp
);

    cache_pkg::bank_id_t ptr_q;
    cache_pkg::bank_id_t owner_q;
    cache_pkg::bank_id_t pick;
    cache_pkg::bank_id_t cand;
    logic                busy_q;
    logic                found;

    // Round-robin search from the pointer
    always_comb begin
        pick  = ptr_q;
        found = 1'b0;
        cand  = ptr_q;
        for (int i = 0; i < cache_pkg::NUM_BANKS; i++) begin
            cand = cache_pkg::bank_id_t'((int'(ptr_q) + i) % cache_pkg::NUM_BANKS);
            if (!found && bank_mem_req[cand].valid) begin
                pick  = cand;
                found = 1'b1;
            end
        end
    end

    assign mem_req = busy_q ? bank_mem_req[owner_q] : '0;

    always_comb begin
        for (int b = 0; b < cache_pkg::NUM_BANKS; b++) begin
            bank_mem_rsp[b].done  = busy_q && (owner_q == cache_pkg::bank_id_t'(b)) &&
                                    mem_rsp.done;
            bank_mem_rsp[b].rdata = mem_rsp.rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q  <= 1'b0;
            ptr_q   <= '0;
            owner_q <= '0;
        end else if (!busy_q) begin
            if (found) begin
                busy_q  <= 1'b1;
                owner_q <= pick;
            end
        end else if (mem_rsp.done) begin
            busy_q <= 1'b0;
            ptr_q  <= cache_pkg::bank_id_t'((int'(owner_q) + 1) % cache_pkg::NUM_BANKS);
        end
    end

endmodule

/* hw/cache_bank.sv */
module cache_bank #(
    parameter int BANK_ID = 0
) (
    input  logic                 clk,
    input  logic                 rst,
    input  cache_pkg::bank_req_t req,
    output cache_pkg::bank_rsp_t rsp,
    input  logic                 flush_start,
    output logic                 flush_done,
    output cache_pkg::mem_req_t  mem_req,
    input  cache_pkg::mem_rsp_t  mem_rsp
);

    cache_pkg::line_t        data_arr [cache_pkg::SETS];
    cache_pkg::tag_t         tag_arr  [cache_pkg::SETS];
    logic [cache_pkg::SETS-1:0] valid_q;
    logic [cache_pkg::SETS-1:0] dirty_q;

    cache_pkg::bank_state_e  state_q;
    cache_pkg::bank_req_t    req_q;
    logic                    active_q;
    logic                    missed_q;
    cache_pkg::index_t       scan_q;

    cache_pkg::bank_id_t     bank_bit;
    cache_pkg::index_t       cur_idx;
    cache_pkg::line_t        cur_line;
    logic                    flushing;
    logic                    tag_hit;
    logic                    last_set;
    logic                    accept;
    logic                    wr_hit;
    logic                    fill;

    assign bank_bit = cache_pkg::bank_id_t'(BANK_ID);
    assign flushing = (state_q == cache_pkg::FLUSH_SCAN) || (state_q == cache_pkg::FLUSH_WRITE);
    assign cur_idx  = flushing ? scan_q : req_q.index;
    assign cur_line = data_arr[cur_idx];
    assign tag_hit  = valid_q[cur_idx] && (tag_arr[cur_idx] == req_q.tag);
    assign last_set = (scan_q == cache_pkg::index_t'(cache_pkg::SETS - 1));

    assign accept = (state_q == cache_pkg::COMPARE_TAG) && !active_q && !flush_start && req.valid;
    assign wr_hit = rsp.done && req_q.write;
    assign fill   = (state_q == cache_pkg::ALLOCATE) && mem_rsp.done;

    always_comb begin
        rsp.done  = active_q && (state_q == cache_pkg::COMPARE_TAG) && tag_hit;
        rsp.hit   = !missed_q;
        rsp.rdata = req_q.word_sel ? cur_line[63:32] : cur_line[31:0];
    end

    // Victim and refill traffic
    always_comb begin
        mem_req.valid     = 1'b0;
        mem_req.write     = 1'b0;
        mem_req.line_addr = {tag_arr[cur_idx], cur_idx, bank_bit};
        mem_req.wdata     = cur_line;
        case (state_q)
            cache_pkg::WRITE_BACK, cache_pkg::FLUSH_WRITE: begin
                mem_req.valid = 1'b1;
                mem_req.write = 1'b1;
            end
            cache_pkg::ALLOCATE: begin
                mem_req.valid     = 1'b1;
                mem_req.line_addr = {req_q.tag, cur_idx, bank_bit};
            end
            default: begin
                mem_req.valid = 1'b0;
            end
        endcase
    end

    // ******************************
    // Controller
    // ******************************
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= cache_pkg::COMPARE_TAG;
            active_q   <= 1'b0;
            missed_q   <= 1'b0;
            scan_q     <= '0;
            valid_q    <= '0;
            dirty_q    <= '0;
            flush_done <= 1'b0;
        end else begin
            flush_done <= 1'b0;
            case (state_q)
                cache_pkg::COMPARE_TAG: begin
                    if (flush_start) begin
                        state_q <= cache_pkg::FLUSH_SCAN;
                        scan_q  <= '0;
                    end else if (accept) begin
                        active_q <= 1'b1;
                        missed_q <= 1'b0;
                    end else if (active_q && tag_hit) begin
                        active_q <= 1'b0;
                        if (req_q.write) begin
                            dirty_q[cur_idx] <= 1'b1;
                        end
                    end else if (active_q) begin
                        missed_q <= 1'b1;
                        state_q  <= (valid_q[cur_idx] && dirty_q[cur_idx]) ?
                                    cache_pkg::WRITE_BACK : cache_pkg::ALLOCATE;
                    end
                end
                cache_pkg::WRITE_BACK: begin
                    if (mem_rsp.done) begin
                        state_q <= cache_pkg::ALLOCATE;
                    end
                end
                cache_pkg::ALLOCATE: begin
                    if (mem_rsp.done) begin
                        valid_q[cur_idx] <= 1'b1;
                        dirty_q[cur_idx] <= 1'b0;
                        state_q          <= cache_pkg::COMPARE_TAG;  // Retry hits now
                    end
                end
                cache_pkg::FLUSH_SCAN: begin
                    if (valid_q[scan_q] && dirty_q[scan_q]) begin
                        state_q <= cache_pkg::FLUSH_WRITE;
                    end else begin
                        valid_q[scan_q] <= 1'b0;
                        if (last_set) begin
                            flush_done <= 1'b1;
                            state_q    <= cache_pkg::COMPARE_TAG;
                        end else begin
                            scan_q <= scan_q + 1'b1;
                        end
                    end
                end
                cache_pkg::FLUSH_WRITE: begin
                    if (mem_rsp.done) begin
                        dirty_q[scan_q] <= 1'b0;  // Rescan clears valid
                        state_q         <= cache_pkg::FLUSH_SCAN;
                    end
                end
                default: begin
                    state_q <= cache_pkg::COMPARE_TAG;
                end
            endcase
        end
    end

    // Line storage and byte merge
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
        if (wr_hit) begin
            for (int i = 0; i < 4; i++) begin
                if (req_q.strb[i]) begin
                    data_arr[cur_idx][req_q.word_sel * 32 + i * 8 +: 8] <= req_q.wdata[i * 8 +: 8];
                end
            end
        end
        if (fill) begin
            data_arr[cur_idx] <= mem_rsp.rdata;
            tag_arr[cur_idx]  <= req_q.tag;
        end
    end

endmodule

/* hw/apb_cache_port.sv */
module apb_cache_port (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  logic [cache_pkg::ADDR_W-1:0]   paddr,
    input  cache_pkg::word_t               pwdata,
    input  cache_pkg::strb_t               pstrb,
    output cache_pkg::word_t               prdata,
    output logic                           pready,
    output logic                           pslverr,
    output cache_pkg::bank_req_t           bank_req [cache_pkg::NUM_BANKS],
    input  cache_pkg::bank_rsp_t           bank_rsp [cache_pkg::NUM_BANKS],
    output logic                           flush_start,
    input  logic [cache_pkg::NUM_BANKS-1:0] flush_done
);

    logic                           access;
    logic                           ctrl_win;
    cache_pkg::bank_id_t            sel;
    logic [cache_pkg::ADDR_W-2:0]   ofs;
    logic                           flush_wr;
    logic                           flush_all;
    logic                           flush_busy_q;
    logic [cache_pkg::NUM_BANKS-1:0] flush_mask_q;
    cache_pkg::count_t              hits_q;
    cache_pkg::count_t              misses_q;
    logic                           any_done;
    logic                           any_hit;

    assign access   = psel && penable;
    assign ctrl_win = paddr[cache_pkg::ADDR_W-1];
    assign sel      = cache_pkg::bank_id_t'(paddr[cache_pkg::BANK_BIT]);
    assign ofs      = paddr[cache_pkg::ADDR_W-2:0];
    assign flush_wr = ctrl_win && pwrite && (ofs == cache_pkg::CTRL_FLUSH_OFS);

    assign flush_start = access && flush_wr && !flush_busy_q;
    assign flush_all   = flush_busy_q && (&(flush_mask_q | flush_done));

    // ******************************
    // Bank requests
    // ******************************
    always_comb begin
        for (int b = 0; b < cache_pkg::NUM_BANKS; b++) begin
            bank_req[b].valid    = access && !ctrl_win && (sel == cache_pkg::bank_id_t'(b));
            bank_req[b].write    = pwrite;
            bank_req[b].word_sel = paddr[2];  // Word within line
            bank_req[b].index    = paddr[cache_pkg::INDEX_LSB +: cache_pkg::INDEX_W];
            bank_req[b].tag      = paddr[cache_pkg::TAG_LSB +: cache_pkg::TAG_W];
            bank_req[b].wdata    = pwdata;
            bank_req[b].strb     = pwrite ? pstrb : '0;
        end
    end

    // APB completion
    always_comb begin
        prdata  = '0;
        pready  = 1'b0;
        pslverr = 1'b0;
        if (access) begin
            if (!ctrl_win) begin
                pready = bank_rsp[sel].done;
                prdata = bank_rsp[sel].rdata;
            end else if (pwrite) begin
                if (flush_wr) begin
                    pready = flush_all;   // Held until every bank is clean
                end else begin
                    pready  = 1'b1;
                    pslverr = 1'b1;       // Counters are read only
                end
            end else begin
                pready = 1'b1;
                case (ofs)
                    cache_pkg::CTRL_FLUSH_OFS:  prdata = '0;
                    cache_pkg::CTRL_HITS_OFS:   prdata = hits_q;
                    cache_pkg::CTRL_MISSES_OFS: prdata = misses_q;
                    default:                    pslverr = 1'b1;
                endcase
            end
        end
    end

    always_comb begin
        any_done = 1'b0;
        any_hit  = 1'b0;
        for (int b = 0; b < cache_pkg::NUM_BANKS; b++) begin
            if (bank_rsp[b].done) begin
                any_done = 1'b1;
                any_hit  = bank_rsp[b].hit;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hits_q       <= '0;
            misses_q     <= '0;
            flush_busy_q <= 1'b0;
            flush_mask_q <= '0;
        end else begin
            if (any_done && any_hit) begin
                hits_q <= hits_q + 1'b1;
            end
            if (any_done && !any_hit) begin
                misses_q <= misses_q + 1'b1;
            end
            if (flush_start) begin
                flush_busy_q <= 1'b1;
                flush_mask_q <= '0;
            end else if (flush_all) begin
                flush_busy_q <= 1'b0;
                flush_mask_q <= '0;
            end else if (flush_busy_q) begin
                flush_mask_q <= flush_mask_q | flush_done;  // Banks finish at different times
            end
        end
    end

endmodule

/* hw/cache_pkg.sv */
package cache_pkg;

    // ******************************
    // Address map
    // ******************************
    localparam int ADDR_W      = 17;   // Bit 16 picks the control window
    localparam int NUM_BANKS   = 2;
    localparam int SETS        = 64;
    localparam int OFFSET_W    = 3;
    localparam int BANK_BIT    = 3;
    localparam int INDEX_LSB   = 4;
    localparam int INDEX_W     = 6;
    localparam int TAG_LSB     = 10;
    localparam int TAG_W       = 6;
    localparam int MEM_LATENCY = 2;

    localparam int CTRL_FLUSH_OFS  = 0;
    localparam int CTRL_HITS_OFS   = 4;
    localparam int CTRL_MISSES_OFS = 8;

    // ******************************
    // Vector types
    // ******************************
    typedef logic [31:0]                      word_t;
    typedef logic [63:0]                      line_t;
    typedef logic [3:0]                       strb_t;
    typedef logic [TAG_W-1:0]                 tag_t;
    typedef logic [INDEX_W-1:0]               index_t;
    typedef logic [ADDR_W-OFFSET_W-2:0]       line_addr_t;  // Tag, index, bank bit
    typedef logic [31:0]                      count_t;
    typedef logic [$clog2(NUM_BANKS)-1:0]     bank_id_t;

    typedef struct packed {
        logic   valid;
        logic   write;
        logic   word_sel;
        index_t index;
        tag_t   tag;
        word_t  wdata;
        strb_t  strb;
    } bank_req_t;

    typedef struct packed {
        logic  done;
        logic  hit;
        word_t rdata;
    } bank_rsp_t;

    typedef struct packed {
        logic       valid;
        logic       write;
        line_addr_t line_addr;
        line_t      wdata;
    } mem_req_t;

    typedef struct packed {
        logic  done;
        line_t rdata;
    } mem_rsp_t;

    typedef enum logic [2:0] {
        COMPARE_TAG,
        WRITE_BACK,
        ALLOCATE,
        FLUSH_SCAN,
        FLUSH_WRITE
    } bank_state_e;

endpackage
